// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_yolo_write_ctrl -f project.f
	./obj_dir/Vtb_yolo_write_ctrl

clean:
	rm -rf obj_dir

// ==== project.f ====
+incdir+verilog
verilog/yolo_write_pkg.sv
verilog/conf_regs.sv
verilog/shadow_pipe.sv
verilog/stage_addr_calc.sv
verilog/dma_len_counter.sv
verilog/load_sequencer.sv
verilog/write_sequencer.sv
verilog/yolo_write_ctrl.sv
test/tb_yolo_write_ctrl.sv

// ==== test/tb_yolo_write_ctrl.sv ====
`default_nettype none

`include "yolo_write_defines.svh"

module tb_yolo_write_ctrl;
   import yolo_write_pkg::*;

   logic clk;
   logic rst;
   logic clear;
   logic run;
   logic cfg_valid;
   logic cfg_wstrb;
   logic [`CONF_ADDR_W-1:0] cfg_addr;
   logic [`IO_ADDR_W-1:0] cfg_wdata;
   logic rd_ready;
   logic done;
   dma_len_t dma_len;
   stage_addr_t stage_addr;
   ld_ctrl_t ld;
   wr_ctrl_t wr;

   // reference model of the working registers and shadow pipelines
   logic [`IO_ADDR_W-1:0] m_base;
   logic [`IO_ADDR_W/2-1:0] m_offset;
   logic [`AXI_LEN_W-1:0] m_wr_len;
   logic [`LEN_W-1:0] m_rd_len;
   wr_seq_cfg_t m_wr_seq;
   yolo_cfg_t m_yolo;
   logic [`IO_ADDR_W-1:0] p_base [3];
   logic [`IO_ADDR_W/2-1:0] p_offset [3];
   logic [`AXI_LEN_W-1:0] p_len [3];
   wr_seq_cfg_t p_wr_seq [2];
   yolo_cfg_t p_yolo [2];
   logic [`LEN_W-1:0] rd_cnt;
   logic [`LEN_W-1:0] rd_shadow;
   int rd_reloads;
   logic [1:0] mp_cnt;
   logic m_run_q;

   int seed;
   int acc_count;
   int res_count;
   int en_count;
   int bit_count [`N_VECT];
   logic [`PIXEL_ADDR_W-1:0] bit_addr [`N_VECT];
   logic [`PIXEL_ADDR_W-1:0] addr_seen [$];

   yolo_write_ctrl i_yolo_write_ctrl (
      .clk(clk), .rst(rst), .clear(clear), .run(run),
      .cfg_valid(cfg_valid), .cfg_wstrb(cfg_wstrb),
      .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata), .rd_ready(rd_ready),
      .done(done), .dma_len(dma_len), .stage_addr(stage_addr),
      .ld(ld), .wr(wr)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic stop_on_error(input string line);
      $display("%s", line);
      $display("sim failed");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [127:0] got,
                              input logic [127:0] exp);
      assert (got === exp)
      else stop_on_error($sformatf("mismatch at %0t: %s got %0h expected %0h",
                                   $time, name, got, exp));
   endtask

   function automatic stage_addr_t stage_addr_of(input logic [`IO_ADDR_W-1:0] base,
                                                 input logic [`IO_ADDR_W/2-1:0] offset);
      stage_addr_t addr;
      for (int i = 0; i < `N_STAGES; i++)
         addr[i] = base + `IO_ADDR_W'(i) * `IO_ADDR_W'(offset);
      return addr;
   endfunction

   function automatic logic [`AXI_LEN_W-1:0] saturate_len(input logic [`LEN_W-1:0] cnt);
      if (cnt >= `LEN_W'(1 << `AXI_LEN_W))
         return '1;
      else
         return cnt[`AXI_LEN_W-1:0];
   endfunction

   // address of the k-th write in a sequence
   function automatic logic [`PIXEL_ADDR_W-1:0] write_addr(input wr_seq_cfg_t c, input int k);
      int m;
      int p;
      m = k / int'(c.per);
      p = k % int'(c.per);
      return c.start + `PIXEL_ADDR_W'(m) * c.incr + `PIXEL_ADDR_W'(p);
   endfunction

   always @(posedge clk or posedge rst) begin
      if (rst) begin
         m_base <= '0;
         m_offset <= '0;
         m_wr_len <= '0;
         m_rd_len <= '0;
         m_wr_seq <= '0;
         m_yolo <= '0;
         for (int i = 0; i < 3; i++) begin
            p_base[i] <= '0;
            p_offset[i] <= '0;
            p_len[i] <= '0;
         end
         p_wr_seq[0] <= '0;
         p_wr_seq[1] <= '0;
         p_yolo[0] <= '0;
         p_yolo[1] <= '0;
         rd_cnt <= '0;
         rd_shadow <= '0;
         rd_reloads <= 0;
         mp_cnt <= '0;
         m_run_q <= 1'b0;
      end else begin
         if (clear) begin
            m_base <= '0;
            m_offset <= '0;
            m_wr_len <= '0;
            m_rd_len <= '0;
            m_wr_seq <= '0;
            m_yolo <= '0;
         end else if (cfg_valid && cfg_wstrb) begin
            case (cfg_addr)
               WR_EXT_ADDR: m_base <= cfg_wdata;
               WR_OFFSET: m_offset <= cfg_wdata[`IO_ADDR_W/2-1:0];
               WR_LEN: m_wr_len <= cfg_wdata[`AXI_LEN_W-1:0];
               WR_START: m_wr_seq.start <= cfg_wdata[`PIXEL_ADDR_W-1:0];
               WR_ITER: m_wr_seq.iter <= cfg_wdata[`PIXEL_ADDR_W-1:0];
               WR_PER: m_wr_seq.per <= cfg_wdata[`PIXEL_ADDR_W-1:0];
               WR_INCR: m_wr_seq.incr <= cfg_wdata[`PIXEL_ADDR_W-1:0];
               WR_DELAY: m_wr_seq.delay <= cfg_wdata[`PIXEL_ADDR_W-1:0];
               RD_LEN: m_rd_len <= cfg_wdata[`LEN_W-1:0];
               YOLO_ITER: m_yolo.iter <= cfg_wdata[`PIXEL_ADDR_W-1:0];
               YOLO_PER: m_yolo.per <= cfg_wdata[`PIXEL_ADDR_W-1:0];
               YOLO_BYPASS: m_yolo.bypass <= cfg_wdata[0];
               YOLO_MAXPOOL: m_yolo.maxpool <= cfg_wdata[0];
               default: ;
            endcase
         end
         if (run) begin
            p_base[0] <= m_base;
            p_offset[0] <= m_offset;
            p_len[0] <= m_wr_len;
            for (int i = 1; i < 3; i++) begin
               p_base[i] <= p_base[i-1];
               p_offset[i] <= p_offset[i-1];
               p_len[i] <= p_len[i-1];
            end
            p_wr_seq[0] <= m_wr_seq;
            p_wr_seq[1] <= p_wr_seq[0];
            p_yolo[0] <= m_yolo;
            p_yolo[1] <= p_yolo[0];
            rd_cnt <= m_rd_len;
            rd_shadow <= m_rd_len;
         end else if (rd_ready) begin
            if (rd_cnt == '0) begin
               rd_cnt <= rd_shadow;
               rd_reloads <= rd_reloads + 1;
            end else begin
               rd_cnt <= rd_cnt - 1'b1;
            end
         end
         m_run_q <= run;
         // maxpool counter restarts with each layer
         if (m_run_q)
            mp_cnt <= (p_yolo[1].maxpool && !p_yolo[1].bypass) ? 2'd3 : 2'd0;
         else if (ld.res)
            mp_cnt <= mp_cnt + 1'b1;
      end
   end

   always @(negedge clk) begin
      if (!rst) begin
         check_value("stage_addr", stage_addr, stage_addr_of(p_base[2], p_offset[2]));
         check_value("dma_len.wr_len", dma_len.wr_len, p_len[2]);
         check_value("dma_len.rd_len", dma_len.rd_len, saturate_len(rd_cnt));
         check_value("ld.mp", ld.mp, mp_cnt != 2'd0);
         if (p_yolo[1].bypass)
            check_value("ld.res", ld.res, 1'b1);
         if (ld.acc)
            acc_count++;
         if (ld.res)
            res_count++;
         if (|wr.en) begin
            en_count++;
            addr_seen.push_back(wr.addr);
         end
         for (int j = 0; j < `N_VECT; j++) begin
            if (wr.en[j]) begin
               bit_count[j]++;
               bit_addr[j] = wr.addr;
            end
         end
      end
   end

   a_en_shape: assert property (
      @(posedge clk) disable iff (rst)
      p_yolo[1].bypass ? $onehot0(wr.en) : (wr.en == '0 || wr.en == '1)
   ) else stop_on_error($sformatf("wr.en has a wrong bit pattern at %0t: %b", $time, wr.en));

   a_done_drops: assert property (
      @(posedge clk) disable iff (rst)
      m_run_q && (p_yolo[1].iter != '0 || p_wr_seq[1].iter != '0) |=> !done
   ) else stop_on_error($sformatf("mismatch at %0t: done got 1 expected 0", $time));

   task automatic write_reg(input conf_addr_e addr, input logic [`IO_ADDR_W-1:0] data);
      @(posedge clk);
      cfg_valid <= 1'b1;
      cfg_wstrb <= 1'b1;
      cfg_addr <= addr;
      cfg_wdata <= data;
      @(posedge clk);
      cfg_valid <= 1'b0;
      cfg_wstrb <= 1'b0;
   endtask

   // two idle cycles let the stage address register settle
   task automatic pulse_run();
      repeat (2) @(posedge clk);
      run <= 1'b1;
      @(posedge clk);
      run <= 1'b0;
   endtask

   task automatic pulse_clear();
      @(posedge clk);
      clear <= 1'b1;
      @(posedge clk);
      clear <= 1'b0;
   endtask

   task automatic wait_idle();
      int cycles;
      cycles = 0;
      repeat (2) @(negedge clk);
      while (!done) begin
         @(negedge clk);
         cycles++;
         if (cycles > 5000)
            stop_on_error("timeout while waiting for done to return high");
      end
      // drain the accumulate line and the write output registers
      repeat (4) @(negedge clk);
   endtask

   task automatic clear_counts();
      @(posedge clk);
      acc_count = 0;
      res_count = 0;
      en_count = 0;
      addr_seen.delete();
      for (int j = 0; j < `N_VECT; j++) begin
         bit_count[j] = 0;
         bit_addr[j] = '0;
      end
   endtask

   // yolo and write settings need two runs to become active
   task automatic prime_and_run();
      pulse_run();
      wait_idle();
      clear_counts();
      pulse_run();
      wait_idle();
   endtask

   initial begin : stimulus
      logic [`IO_ADDR_W-1:0] base [3];
      logic [`IO_ADDR_W/2-1:0] offset [3];
      logic [`AXI_LEN_W-1:0] len [3];
      wr_seq_cfg_t seq;
      int reloads;
      int cycles;
      seed = 35;
      rst = 1'b1;
      clear = 1'b0;
      run = 1'b0;
      cfg_valid = 1'b0;
      cfg_wstrb = 1'b0;
      cfg_addr = '0;
      cfg_wdata = '0;
      rd_ready = 1'b0;
      repeat (2) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      check_value("ld", ld, '0);
      check_value("wr", wr, '0);
      check_value("dma_len", dma_len, '0);
      check_value("stage_addr", stage_addr, '0);
      check_value("done", done, 1'b1);

      // three layers in flight on the external side
      for (int n = 0; n < 5; n++) begin
         if (n < 3) begin
            base[n] = $random(seed);
            offset[n] = $random(seed);
            len[n] = $random(seed);
            write_reg(WR_EXT_ADDR, base[n]);
            write_reg(WR_OFFSET, `IO_ADDR_W'(offset[n]));
            write_reg(WR_LEN, `IO_ADDR_W'(len[n]));
         end
         pulse_run();
         @(negedge clk);
         if (n < 2) begin
            check_value("stage_addr", stage_addr, '0);
            check_value("dma_len.wr_len", dma_len.wr_len, '0);
         end else begin
            check_value("stage_addr", stage_addr, stage_addr_of(base[n-2], offset[n-2]));
            check_value("dma_len.wr_len", dma_len.wr_len, len[n-2]);
         end
      end

      pulse_clear();
      pulse_run();
      write_reg(WR_EXT_ADDR, base[0]);
      write_reg(WR_OFFSET, `IO_ADDR_W'(offset[0]));
      write_reg(WR_LEN, `IO_ADDR_W'(len[0]));
      pulse_run();
      pulse_run();
      @(negedge clk);
      check_value("stage_addr", stage_addr, '0);
      check_value("dma_len.wr_len", dma_len.wr_len, '0);
      pulse_run();
      @(negedge clk);
      check_value("stage_addr", stage_addr, stage_addr_of(base[0], offset[0]));
      check_value("dma_len.wr_len", dma_len.wr_len, len[0]);

      write_reg(YOLO_ITER, 5);
      write_reg(YOLO_PER, 3);
      write_reg(YOLO_MAXPOOL, 1);
      prime_and_run();
      check_value("ld.acc pulses", acc_count, 5);
      check_value("ld.res pulses", res_count, 5);
      check_value("ld.nmac", ld.nmac, 5 % `N_MACS);

      write_reg(YOLO_ITER, 3);
      write_reg(YOLO_PER, 2);
      write_reg(YOLO_BYPASS, 1);
      prime_and_run();
      check_value("ld.acc pulses", acc_count, 3);
      check_value("ld.nmac", ld.nmac, 3 % `N_MACS);

      seq.start = `PIXEL_ADDR_W'($random(seed));
      seq.iter = 3;
      seq.per = 4;
      seq.incr = `PIXEL_ADDR_W'($random(seed));
      seq.delay = 2;
      write_reg(YOLO_BYPASS, 0);
      write_reg(YOLO_ITER, 0);
      write_reg(WR_START, `IO_ADDR_W'(seq.start));
      write_reg(WR_ITER, `IO_ADDR_W'(seq.iter));
      write_reg(WR_PER, `IO_ADDR_W'(seq.per));
      write_reg(WR_INCR, `IO_ADDR_W'(seq.incr));
      write_reg(WR_DELAY, `IO_ADDR_W'(seq.delay));
      prime_and_run();
      check_value("wr.en cycles", en_count, 12);
      for (int k = 0; k < en_count; k++)
         check_value($sformatf("wr.addr[%0d]", k), addr_seen[k], write_addr(seq, k));

      // bypass spreads the writes over the vector memories
      seq.iter = 4;
      seq.per = 5;
      write_reg(WR_ITER, `IO_ADDR_W'(seq.iter));
      write_reg(WR_PER, `IO_ADDR_W'(seq.per));
      write_reg(YOLO_BYPASS, 1);
      prime_and_run();
      for (int j = 0; j < `N_VECT; j++) begin
         check_value($sformatf("wr.en[%0d] pulses", j), bit_count[j], 1);
         check_value($sformatf("wr.addr at wr.en[%0d]", j), bit_addr[j],
                     write_addr(seq, 4 * j + 3));
      end

      write_reg(RD_LEN, 260);
      pulse_run();
      // working length changes, the reload must still use the shadow
      write_reg(RD_LEN, 7);
      reloads = rd_reloads;
      cycles = 0;
      while (rd_reloads == reloads) begin
         @(posedge clk);
         rd_ready <= ($random(seed) % 2) != 0;
         cycles++;
         if (cycles > 4000)
            stop_on_error("read burst length never reloaded after reaching zero");
      end
      @(negedge clk);
      check_value("dma_len.rd_len", dma_len.rd_len, 8'hff);
      repeat (20) begin
         @(posedge clk);
         rd_ready <= ($random(seed) % 2) != 0;
      end
      @(posedge clk);
      rd_ready <= 1'b0;
      wait_idle();

      $display("sim passed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog/conf_regs.sv ====
`default_nettype none

`include "yolo_write_defines.svh"

module conf_regs (
   input wire clk,
   input wire rst,
   input wire clear,
   input wire cfg_valid,
   input wire cfg_wstrb,
   input wire [`CONF_ADDR_W-1:0] cfg_addr,
   input wire [`IO_ADDR_W-1:0] cfg_wdata,
   output yolo_write_pkg::conf_t conf
);
   import yolo_write_pkg::*;

   // working registers, loaded straight from the cpu word
   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         conf <= '0;
      end else if (clear) begin
         conf <= '0;
      end else if (cfg_valid && cfg_wstrb) begin
         case (cfg_addr)
            WR_EXT_ADDR:
               conf.ext_addr <= cfg_wdata;
            WR_OFFSET:
               conf.offset <= cfg_wdata[`IO_ADDR_W/2-1:0];
            WR_LEN:
               conf.wr_len <= cfg_wdata[`AXI_LEN_W-1:0];
            WR_START:
               conf.wr_seq.start <= cfg_wdata[`PIXEL_ADDR_W-1:0];
            WR_ITER:
               conf.wr_seq.iter <= cfg_wdata[`PIXEL_ADDR_W-1:0];
            WR_PER:
               conf.wr_seq.per <= cfg_wdata[`PIXEL_ADDR_W-1:0];
            WR_INCR:
               conf.wr_seq.incr <= cfg_wdata[`PIXEL_ADDR_W-1:0];
            WR_DELAY:
               conf.wr_seq.delay <= cfg_wdata[`PIXEL_ADDR_W-1:0];
            RD_LEN:
               conf.rd_len <= cfg_wdata[`LEN_W-1:0];
            YOLO_ITER:
               conf.yolo.iter <= cfg_wdata[`PIXEL_ADDR_W-1:0];
            YOLO_PER:
               conf.yolo.per <= cfg_wdata[`PIXEL_ADDR_W-1:0];
            // flags take bit 0
            YOLO_BYPASS:
               conf.yolo.bypass <= cfg_wdata[0];
            YOLO_MAXPOOL:
               conf.yolo.maxpool <= cfg_wdata[0];
            default: ;
         endcase
      end
   end

   a_cfg_addr_known: assert property (
      @(posedge clk) disable iff (rst) cfg_valid |-> !$isunknown(cfg_addr)
   );

endmodule

`default_nettype wire

// ==== verilog/dma_len_counter.sv ====
`default_nettype none

`include "yolo_write_defines.svh"

module dma_len_counter (
   input wire clk,
   input wire rst,
   input wire run,
   input wire rd_ready,
   input wire [`LEN_W-1:0] rd_len,
   output logic [`AXI_LEN_W-1:0] burst_len
);

   logic [`LEN_W-1:0] cnt;
   logic [`LEN_W-1:0] len_shadow;

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         cnt <= '0;
         len_shadow <= '0;
      end else if (run) begin
         cnt <= rd_len;
         len_shadow <= rd_len;
      end else if (rd_ready) begin
         // wrap back to the layer length
         if (cnt == '0)
            cnt <= len_shadow;
         else
            cnt <= cnt - 1'b1;
      end
   end

   assign burst_len = (|cnt[`LEN_W-1:`AXI_LEN_W]) ? '1 : cnt[`AXI_LEN_W-1:0];

endmodule

`default_nettype wire

// ==== verilog/load_sequencer.sv ====
`default_nettype none

`include "yolo_write_defines.svh"

module load_sequencer (
   input wire clk,
   input wire rst,
   input wire start,
   input wire yolo_write_pkg::yolo_cfg_t cfg,
   output yolo_write_pkg::ld_ctrl_t ld,
   output logic busy
);
   import yolo_write_pkg::*;

   logic [`PIXEL_ADDR_W-1:0] wait_cnt;
   logic [`PIXEL_ADDR_W-1:0] addr;
   logic [`PIXEL_ADDR_W-1:0] iter_cnt;
   logic hit;
   logic [2:0] acc_line;
   logic [1:0] mp_cnt;
   logic [NMAC_W-1:0] nmac;

   // start of each accumulate window
   assign hit = busy && (wait_cnt == '0) && (addr == '0);

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         busy <= 1'b0;
         wait_cnt <= '0;
         addr <= '0;
         iter_cnt <= '0;
      end else if (start) begin
         busy <= (cfg.iter != '0);
         wait_cnt <= `PIXEL_ADDR_W'(`READ_LAT);
         addr <= '0;
         iter_cnt <= '0;
      end else if (busy) begin
         if (wait_cnt != '0) begin
            wait_cnt <= wait_cnt - 1'b1;
         end else if (addr == cfg.per - 1'b1) begin
            addr <= '0;
            if (iter_cnt == cfg.iter - 1'b1)
               busy <= 1'b0;
            else
               iter_cnt <= iter_cnt + 1'b1;
         end else begin
            addr <= addr + 1'b1;
         end
      end
   end

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         acc_line <= '0;
         mp_cnt <= '0;
         nmac <= '0;
      end else if (start) begin
         acc_line <= '0;
         nmac <= '0;
         mp_cnt <= (cfg.maxpool && !cfg.bypass) ? 2'd3 : 2'd0;
      end else begin
         acc_line <= {acc_line[1:0], hit};
         if (ld.res)
            mp_cnt <= mp_cnt + 1'b1;
         if (acc_line[2])
            nmac <= nmac + 1'b1;
      end
   end

   assign ld.acc = acc_line[0];
   assign ld.res = acc_line[2] || cfg.bypass;
   assign ld.mp = (mp_cnt != 2'd0);
   assign ld.nmac = nmac;

   a_acc_from_busy: assert property (
      @(posedge clk) disable iff (rst) ld.acc |-> $past(busy && (iter_cnt < cfg.iter))
   );

endmodule

`default_nettype wire

// ==== verilog/shadow_pipe.sv ====
`default_nettype none

module shadow_pipe #(
   parameter type payload_t = logic,
   parameter int stages = 1
) (
   input wire clk,
   input wire rst,
   input wire run,
   input wire payload_t d,
   output payload_t q
);

   payload_t pipe [stages];

   // one layer per slot, oldest at the end
   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         for (int i = 0; i < stages; i++)
            pipe[i] <= '0;
      end else if (run) begin
         pipe[0] <= d;
         for (int i = 1; i < stages; i++)
            pipe[i] <= pipe[i-1];
      end
   end

   assign q = pipe[stages-1];

endmodule

`default_nettype wire

// ==== verilog/stage_addr_calc.sv ====
`default_nettype none

`include "yolo_write_defines.svh"

module stage_addr_calc (
   input wire clk,
   input wire rst,
   input wire [`IO_ADDR_W-1:0] base,
   input wire [`IO_ADDR_W/2-1:0] offset,
   output yolo_write_pkg::stage_addr_t stage_addr
);

   // base + i*offset, one registered step
   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         stage_addr <= '0;
      end else begin
         for (int i = 0; i < `N_STAGES; i++)
            stage_addr[i] <= base + `IO_ADDR_W'(i) * offset;
      end
   end

endmodule

`default_nettype wire

// ==== verilog/write_sequencer.sv ====
`default_nettype none

`include "yolo_write_defines.svh"

module write_sequencer (
   input wire clk,
   input wire rst,
   input wire start,
   input wire bypass,
   input wire yolo_write_pkg::wr_seq_cfg_t cfg,
   output yolo_write_pkg::wr_ctrl_t wr,
   output logic busy
);

   logic [`PIXEL_ADDR_W-1:0] wait_cnt;
   logic [`PIXEL_ADDR_W-1:0] pos;
   logic [`PIXEL_ADDR_W-1:0] iter_cnt;
   logic [`PIXEL_ADDR_W-1:0] row_addr;
   logic [`PIXEL_ADDR_W-1:0] addr_raw;
   logic [`PIXEL_ADDR_W-1:0] addr_q;
   logic [`PIXEL_ADDR_W-1:0] en_cnt;
   logic en_raw;
   logic en_q;
   logic [`N_VECT-1:0] en_dec;

   assign en_raw = busy && (wait_cnt == '0);
   assign addr_raw = row_addr + pos;

   // start + m*incr + p
   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         busy <= 1'b0;
         wait_cnt <= '0;
         pos <= '0;
         iter_cnt <= '0;
         row_addr <= '0;
      end else if (start) begin
         busy <= (cfg.iter != '0);
         wait_cnt <= cfg.delay;
         pos <= '0;
         iter_cnt <= '0;
         row_addr <= cfg.start;
      end else if (busy) begin
         if (wait_cnt != '0) begin
            wait_cnt <= wait_cnt - 1'b1;
         end else if (pos == cfg.per - 1'b1) begin
            pos <= '0;
            row_addr <= row_addr + cfg.incr;
            if (iter_cnt == cfg.iter - 1'b1)
               busy <= 1'b0;
            else
               iter_cnt <= iter_cnt + 1'b1;
         end else begin
            pos <= pos + 1'b1;
         end
      end
   end

   // bypass picks every 4th write for each vector
   always_comb begin
      for (int j = 0; j < `N_VECT; j++) begin
         if (bypass)
            en_dec[j] = en_q && (en_cnt == `PIXEL_ADDR_W'(4 * j + 3));
         else
            en_dec[j] = en_raw;
      end
   end

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         en_q <= 1'b0;
         en_cnt <= '0;
         addr_q <= '0;
         wr <= '0;
      end else begin
         en_q <= en_raw;
         addr_q <= addr_raw;
         wr.en <= en_dec;
         wr.addr <= bypass ? addr_q : addr_raw;
         if (start)
            en_cnt <= '0;
         else if (en_q)
            en_cnt <= en_cnt + 1'b1;
      end
   end

   a_bypass_onehot: assert property (
      @(posedge clk) disable iff (rst) bypass |=> $onehot0(wr.en)
   );

endmodule

`default_nettype wire

// ==== verilog/yolo_write_ctrl.sv ====
`default_nettype none

`include "yolo_write_defines.svh"

module yolo_write_ctrl (
   input wire clk,
   input wire rst,
   input wire clear,
   input wire run,
   input wire cfg_valid,
   input wire cfg_wstrb,
   input wire [`CONF_ADDR_W-1:0] cfg_addr,
   input wire [`IO_ADDR_W-1:0] cfg_wdata,
   input wire rd_ready,
   output logic done,
   output yolo_write_pkg::dma_len_t dma_len,
   output yolo_write_pkg::stage_addr_t stage_addr,
   output yolo_write_pkg::ld_ctrl_t ld,
   output yolo_write_pkg::wr_ctrl_t wr
);
   import yolo_write_pkg::*;

   conf_t conf;
   stage_addr_t calc_addr;
   wr_ext_cfg_t wr_ext_in;
   wr_ext_cfg_t wr_ext_act;
   wr_seq_cfg_t wr_seq_act;
   yolo_cfg_t yolo_act;
   logic [`AXI_LEN_W-1:0] rd_burst;
   logic run_q;
   logic ld_busy;
   logic wr_busy;

   conf_regs i_conf_regs (
      .clk(clk), .rst(rst), .clear(clear),
      .cfg_valid(cfg_valid), .cfg_wstrb(cfg_wstrb),
      .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata),
      .conf(conf)
   );

   stage_addr_calc i_stage_addr_calc (
      .clk(clk), .rst(rst),
      .base(conf.ext_addr), .offset(conf.offset),
      .stage_addr(calc_addr)
   );

   assign wr_ext_in = '{addr: calc_addr, len: conf.wr_len};

   // up to three layers in flight on the external side
   shadow_pipe #(.payload_t(wr_ext_cfg_t), .stages(3)) i_wr_ext_pipe (
      .clk(clk), .rst(rst), .run(run), .d(wr_ext_in), .q(wr_ext_act)
   );

   shadow_pipe #(.payload_t(wr_seq_cfg_t), .stages(2)) i_wr_seq_pipe (
      .clk(clk), .rst(rst), .run(run), .d(conf.wr_seq), .q(wr_seq_act)
   );

   shadow_pipe #(.payload_t(yolo_cfg_t), .stages(2)) i_yolo_pipe (
      .clk(clk), .rst(rst), .run(run), .d(conf.yolo), .q(yolo_act)
   );

   dma_len_counter i_dma_len_counter (
      .clk(clk), .rst(rst), .run(run), .rd_ready(rd_ready),
      .rd_len(conf.rd_len), .burst_len(rd_burst)
   );

   always_ff @(posedge clk, posedge rst) begin
      if (rst)
         run_q <= 1'b0;
      else
         run_q <= run;
   end

   // sequencers start one cycle after run, on the shifted settings
   load_sequencer i_load_sequencer (
      .clk(clk), .rst(rst), .start(run_q),
      .cfg(yolo_act), .ld(ld), .busy(ld_busy)
   );

   write_sequencer i_write_sequencer (
      .clk(clk), .rst(rst), .start(run_q), .bypass(yolo_act.bypass),
      .cfg(wr_seq_act), .wr(wr), .busy(wr_busy)
   );

   assign stage_addr = wr_ext_act.addr;
   assign dma_len = '{wr_len: wr_ext_act.len, rd_len: rd_burst};
   assign done = !ld_busy && !wr_busy;

endmodule

`default_nettype wire

// ==== verilog/yolo_write_defines.svh ====
`ifndef YOLO_WRITE_DEFINES_SVH
`define YOLO_WRITE_DEFINES_SVH

// external bus and length widths
`define IO_ADDR_W 32
`define LEN_W 16
`define AXI_LEN_W 8

// internal addressing
`define PIXEL_ADDR_W 10
`define CONF_ADDR_W 5

`define N_STAGES 4
`define N_VECT 4
`define N_MACS 4
`define READ_LAT 3

`endif

// ==== verilog/yolo_write_pkg.sv ====
`default_nettype none

`include "yolo_write_defines.svh"

package yolo_write_pkg;

   localparam int NMAC_W = (`N_MACS > 1) ? $clog2(`N_MACS) : 1;

   // one word per setting
   typedef enum logic [`CONF_ADDR_W-1:0] {
      WR_EXT_ADDR, WR_OFFSET, WR_LEN, WR_START,
      WR_ITER, WR_PER, WR_INCR, WR_DELAY,
      RD_LEN,
      YOLO_ITER, YOLO_PER, YOLO_BYPASS, YOLO_MAXPOOL
   } conf_addr_e;

   typedef logic [`N_STAGES-1:0][`IO_ADDR_W-1:0] stage_addr_t;

   typedef struct packed {
      stage_addr_t addr;
      logic [`AXI_LEN_W-1:0] len;
   } wr_ext_cfg_t;

   typedef struct packed {
      logic [`PIXEL_ADDR_W-1:0] start;
      logic [`PIXEL_ADDR_W-1:0] iter;
      logic [`PIXEL_ADDR_W-1:0] per;
      logic [`PIXEL_ADDR_W-1:0] incr;
      logic [`PIXEL_ADDR_W-1:0] delay;
   } wr_seq_cfg_t;

   typedef struct packed {
      logic [`PIXEL_ADDR_W-1:0] iter;
      logic [`PIXEL_ADDR_W-1:0] per;
      logic bypass;
      logic maxpool;
   } yolo_cfg_t;

   typedef struct packed {
      logic [`IO_ADDR_W-1:0] ext_addr;
      logic [`IO_ADDR_W/2-1:0] offset;
      logic [`AXI_LEN_W-1:0] wr_len;
      logic [`LEN_W-1:0] rd_len;
      wr_seq_cfg_t wr_seq;
      yolo_cfg_t yolo;
   } conf_t;

   typedef struct packed {
      logic acc;
      logic mp;
      logic res;
      logic [NMAC_W-1:0] nmac;
   } ld_ctrl_t;

   typedef struct packed {
      logic [`N_VECT-1:0] en;
      logic [`PIXEL_ADDR_W-1:0] addr;
   } wr_ctrl_t;

   typedef struct packed {
      logic [`AXI_LEN_W-1:0] wr_len;
      logic [`AXI_LEN_W-1:0] rd_len;
   } dma_len_t;

endpackage

`default_nettype wire
